// ==== run_sim.sh ====
#!/bin/sh
# build the conv layer testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module conv_layer_tb -f sources.f -o conv_layer_sim &&
./obj_dir/conv_layer_sim | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/conv_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic start_req,
	output logic start_ack,
	output logic [bank_addr_bits-1:0] act_raddr0,
	output logic [bank_addr_bits-1:0] act_raddr1,
	output logic [bank_addr_bits-1:0] act_raddr2,
	output logic [bank_addr_bits-1:0] act_raddr3,
	input  act_word_t act_rdata0,
	input  act_word_t act_rdata1,
	input  act_word_t act_rdata2,
	input  act_word_t act_rdata3,
	output logic [weight_addr_bits-1:0] weight_raddr,
	input  weight_word_t weight_rdata,
	output logic [bias_addr_bits-1:0] bias_raddr,
	input  bias_t bias_rdata,
	output logic out_wen0,
	output logic out_wen1,
	output logic out_wen2,
	output logic out_wen3,
	output logic [bank_addr_bits-1:0] out_waddr,
	output logic [mask_bits-1:0] out_wordmask,
	output act_word_t out_wdata
);

	logic issue_valid;
	logic [pos_bits-1:0] issue_row;
	logic [pos_bits-1:0] issue_col;
	logic [ch_bits-1:0] issue_ch;
	logic wload_en;
	logic [ch_bits-1:0] wload_idx;
	logic bload_en;

	logic win_valid;
	act_t [win_taps-1:0] win_act;
	logic [pos_bits-1:0] win_row;
	logic [pos_bits-1:0] win_col;
	logic [ch_bits-1:0] win_ch;

	logic res_valid;
	act_t result;
	logic [pos_bits-1:0] res_row;
	logic [pos_bits-1:0] res_col;
	logic [ch_bits-1:0] res_ch;

	conv_sequencer i_conv_sequencer (
		.clk(clk), .rst_n(rst_n),
		.start_req(start_req), .start_ack(start_ack),
		.act_raddr0(act_raddr0), .act_raddr1(act_raddr1),
		.act_raddr2(act_raddr2), .act_raddr3(act_raddr3),
		.weight_raddr(weight_raddr), .bias_raddr(bias_raddr),
		.issue_valid(issue_valid), .issue_row(issue_row),
		.issue_col(issue_col), .issue_ch(issue_ch),
		.wload_en(wload_en), .wload_idx(wload_idx), .bload_en(bload_en),
		.res_valid(res_valid)
	);

	window_select i_window_select (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_row(issue_row),
		.issue_col(issue_col), .issue_ch(issue_ch),
		.act_rdata0(act_rdata0), .act_rdata1(act_rdata1),
		.act_rdata2(act_rdata2), .act_rdata3(act_rdata3),
		.win_valid(win_valid), .win_act(win_act),
		.win_row(win_row), .win_col(win_col), .win_ch(win_ch)
	);

	conv_mac i_conv_mac (
		.clk(clk), .rst_n(rst_n),
		.wload_en(wload_en), .wload_idx(wload_idx), .weight_rdata(weight_rdata),
		.bload_en(bload_en), .bias_rdata(bias_rdata),
		.win_valid(win_valid), .win_act(win_act),
		.win_row(win_row), .win_col(win_col), .win_ch(win_ch),
		.res_valid(res_valid), .result(result),
		.res_row(res_row), .res_col(res_col), .res_ch(res_ch)
	);

	result_writer i_result_writer (
		.clk(clk), .rst_n(rst_n),
		.res_valid(res_valid), .result(result),
		.res_row(res_row), .res_col(res_col), .res_ch(res_ch),
		.out_wen0(out_wen0), .out_wen1(out_wen1),
		.out_wen2(out_wen2), .out_wen3(out_wen3),
		.out_waddr(out_waddr), .out_wordmask(out_wordmask), .out_wdata(out_wdata)
	);

endmodule

`default_nettype wire

// ==== source/conv_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic wload_en,
	input  logic [ch_bits-1:0] wload_idx,
	input  weight_word_t weight_rdata,
	input  logic bload_en,
	input  bias_t bias_rdata,
	input  logic win_valid,
	input  act_t [win_taps-1:0] win_act,
	input  logic [pos_bits-1:0] win_row,
	input  logic [pos_bits-1:0] win_col,
	input  logic [ch_bits-1:0] win_ch,
	output logic res_valid,
	output act_t result,
	output logic [pos_bits-1:0] res_row,
	output logic [pos_bits-1:0] res_col,
	output logic [ch_bits-1:0] res_ch
);

	weight_word_t weight_q [ch_num]; // one word per input channel
	bias_t bias_q;
	logic signed [prod_bits-1:0] prod_q [win_taps];
	logic prod_valid;
	logic [pos_bits-1:0] prod_row;
	logic [pos_bits-1:0] prod_col;
	logic [ch_bits-1:0] prod_ch;
	logic signed [sum_bits-1:0] acc;
	logic signed [sum_bits-1:0] shifted;
	act_t clamped;

	always_ff @(posedge clk) begin
		if (wload_en)
			weight_q[wload_idx] <= weight_rdata;
		if (bload_en)
			bias_q <= bias_rdata;
	end

	// products, tap k of a weight word at byte k from the top
	always_ff @(posedge clk) begin
		for (int ic = 0; ic < ch_num; ic++) begin
			for (int k = 0; k < taps; k++) begin
				prod_q[ic*taps + k] <= $signed(win_act[ic*taps + k]) *
					$signed(weight_q[ic][(taps - k)*param_bits - 1 -: param_bits]);
			end
		end
		prod_row <= win_row;
		prod_col <= win_col;
		prod_ch <= win_ch;
	end

	always_comb begin
		acc = sum_bits'(bias_q);
		for (int i = 0; i < win_taps; i++)
			acc = acc + sum_bits'(prod_q[i]);
		shifted = acc >>> frac_shift;
		if (shifted < 0)
			clamped = '0; // relu
		else if (shifted > act_max)
			clamped = act_t'(act_max);
		else
			clamped = act_t'(shifted);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			res_valid <= prod_valid;
		end
	end

	always_ff @(posedge clk) begin
		result <= clamped;
		res_row <= prod_row;
		res_col <= prod_col;
		res_ch <= prod_ch;
	end

endmodule

`default_nettype wire

// ==== source/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	localparam int act_bits = 12;
	localparam int param_bits = 8;
	localparam int ch_num = 4;
	localparam int oc_num = 4;
	localparam int kernel_dim = 3;
	localparam int in_dim = 8;
	localparam int out_dim = 6;
	localparam int bank_depth = 4;
	localparam int bank_addr_bits = $clog2(bank_depth);
	localparam int block_pitch = 2; // words per block-row inside one bank
	localparam int lanes_per_word = 4;
	localparam int word_bits = ch_num * lanes_per_word * act_bits;
	localparam int mask_bits = ch_num * lanes_per_word;
	localparam int weight_addr_bits = 4;
	localparam int bias_addr_bits = 2;

	localparam int taps = kernel_dim * kernel_dim;
	localparam int win_taps = ch_num * taps;
	localparam int pos_bits = $clog2(out_dim);
	localparam int ch_bits = $clog2(ch_num); // input and output channel index
	localparam int blk_bits = $clog2(in_dim / 2);
	localparam int slot_bits = $clog2(mask_bits);
	localparam int prod_bits = act_bits + param_bits;
	localparam int sum_bits = prod_bits + $clog2(win_taps) + 1; // 36 products plus bias

	localparam int frac_shift = 7;
	localparam int act_max = 2047;

	typedef logic [word_bits-1:0] act_word_t;
	typedef logic [taps*param_bits-1:0] weight_word_t; // tap 0 in the top byte
	typedef logic signed [param_bits-1:0] bias_t;
	typedef logic signed [act_bits-1:0] act_t;

	typedef enum logic [2:0] {st_idle, st_load, st_compute, st_drain, st_done} seq_state_t;

	// slot 0 (channel 0, lane 0) sits in the top bits, mask bit order is the same
	function automatic int slot_lsb(input int slot);
		return word_bits - (slot + 1) * act_bits;
	endfunction

	function automatic logic [bank_addr_bits-1:0] block_addr(input logic [blk_bits-1:0] br,
			input logic [blk_bits-1:0] bc);
		return bank_addr_bits'((br >> 1) * block_pitch + (bc >> 1));
	endfunction

endpackage

`default_nettype wire

// ==== source/conv_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic start_req,
	output logic start_ack,
	output logic [bank_addr_bits-1:0] act_raddr0,
	output logic [bank_addr_bits-1:0] act_raddr1,
	output logic [bank_addr_bits-1:0] act_raddr2,
	output logic [bank_addr_bits-1:0] act_raddr3,
	output logic [weight_addr_bits-1:0] weight_raddr,
	output logic [bias_addr_bits-1:0] bias_raddr,
	output logic issue_valid,
	output logic [pos_bits-1:0] issue_row,
	output logic [pos_bits-1:0] issue_col,
	output logic [ch_bits-1:0] issue_ch,
	output logic wload_en,
	output logic [ch_bits-1:0] wload_idx,
	output logic bload_en,
	input  logic res_valid
);

	seq_state_t state;
	logic [2:0] load_cnt; // 0..3 weights, 4 bias
	logic [pos_bits-1:0] row;
	logic [pos_bits-1:0] col;
	logic [ch_bits-1:0] oc;
	logic [2:0] in_flight; // issued pixels not yet out of the mac
	logic issue;
	logic last_col;
	logic last_pos;
	logic [blk_bits-1:0] blk_r;
	logic [blk_bits-1:0] blk_c;
	logic [blk_bits-1:0] br_even;
	logic [blk_bits-1:0] br_odd;
	logic [blk_bits-1:0] bc_even;
	logic [blk_bits-1:0] bc_odd;

	assign issue = (state == st_compute);
	assign last_col = (col == pos_bits'(out_dim - 1));
	assign last_pos = last_col && (row == pos_bits'(out_dim - 1));

	// the window spans block rows blk_r and blk_r+1, so one of each parity
	assign blk_r = blk_bits'(row >> 1);
	assign blk_c = blk_bits'(col >> 1);
	assign br_even = blk_r[0] ? blk_r + 1'b1 : blk_r;
	assign br_odd = blk_r[0] ? blk_r : blk_r + 1'b1;
	assign bc_even = blk_c[0] ? blk_c + 1'b1 : blk_c;
	assign bc_odd = blk_c[0] ? blk_c : blk_c + 1'b1;

	assign act_raddr0 = block_addr(br_even, bc_even);
	assign act_raddr1 = block_addr(br_even, bc_odd);
	assign act_raddr2 = block_addr(br_odd, bc_even);
	assign act_raddr3 = block_addr(br_odd, bc_odd);

	assign weight_raddr = weight_addr_bits'(oc * ch_num + load_cnt[ch_bits-1:0]);
	assign bias_raddr = bias_addr_bits'(oc);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			load_cnt <= '0;
			row <= '0;
			col <= '0;
			oc <= '0;
			start_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					load_cnt <= '0;
					row <= '0;
					col <= '0;
					oc <= '0;
					if (start_req && !start_ack)
						state <= st_load;
				end
				st_load: begin
					if (load_cnt == 3'(ch_num)) begin // bias read, last load cycle
						load_cnt <= '0;
						state <= st_compute;
					end else begin
						load_cnt <= load_cnt + 1'b1;
					end
				end
				st_compute: begin
					if (last_col) begin
						col <= '0;
						row <= row + 1'b1;
					end else begin
						col <= col + 1'b1;
					end
					if (last_pos) begin
						row <= '0;
						oc <= oc + 1'b1;
						state <= (oc == ch_bits'(oc_num - 1)) ? st_drain : st_load;
					end
				end
				st_drain: begin
					if (in_flight == '0) begin
						start_ack <= 1'b1;
						state <= st_done;
					end
				end
				st_done: begin
					if (!start_req) begin
						start_ack <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_flight <= '0;
		end else begin
			case ({issue, res_valid})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	// control lines one cycle behind the addresses, aligned with read data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
			wload_en <= 1'b0;
			bload_en <= 1'b0;
		end else begin
			issue_valid <= issue;
			wload_en <= (state == st_load) && (load_cnt < 3'(ch_num));
			bload_en <= (state == st_load) && (load_cnt == 3'(ch_num));
		end
	end

	always_ff @(posedge clk) begin
		issue_row <= row;
		issue_col <= col;
		issue_ch <= oc;
		wload_idx <= load_cnt[ch_bits-1:0];
	end

endmodule

`default_nettype wire

// ==== source/result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writer import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic res_valid,
	input  act_t result,
	input  logic [pos_bits-1:0] res_row,
	input  logic [pos_bits-1:0] res_col,
	input  logic [ch_bits-1:0] res_ch,
	output logic out_wen0,
	output logic out_wen1,
	output logic out_wen2,
	output logic out_wen3,
	output logic [bank_addr_bits-1:0] out_waddr,
	output logic [mask_bits-1:0] out_wordmask,
	output act_word_t out_wdata
);

	logic [1:0] bank_sel;
	logic [1:0] lane;
	logic [slot_bits-1:0] slot;
	logic [3:0] wen_next;
	logic [mask_bits-1:0] mask_next;
	act_word_t wdata_next;

	assign bank_sel = {res_row[1], res_col[1]}; // parity of the block row and column
	assign lane = {res_row[0], res_col[0]};
	assign slot = slot_bits'(res_ch * lanes_per_word + lane);

	always_comb begin
		wen_next = '1;
		mask_next = '1;
		wdata_next = '0;
		if (res_valid) begin
			wen_next[bank_sel] = 1'b0;
			mask_next[mask_bits - 1 - int'(slot)] = 1'b0;
		end
		wdata_next[slot_lsb(int'(slot)) +: act_bits] = result;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{out_wen3, out_wen2, out_wen1, out_wen0} <= '1;
			out_wordmask <= '1;
		end else begin
			{out_wen3, out_wen2, out_wen1, out_wen0} <= wen_next;
			out_wordmask <= mask_next;
		end
	end

	always_ff @(posedge clk) begin
		out_waddr <= block_addr(blk_bits'(res_row >> 1), blk_bits'(res_col >> 1));
		out_wdata <= wdata_next;
	end

endmodule

`default_nettype wire

// ==== source/window_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_select import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic issue_valid,
	input  logic [pos_bits-1:0] issue_row,
	input  logic [pos_bits-1:0] issue_col,
	input  logic [ch_bits-1:0] issue_ch,
	input  act_word_t act_rdata0,
	input  act_word_t act_rdata1,
	input  act_word_t act_rdata2,
	input  act_word_t act_rdata3,
	output logic win_valid,
	output act_t [win_taps-1:0] win_act, // index ch*9 + ky*3 + kx
	output logic [pos_bits-1:0] win_row,
	output logic [pos_bits-1:0] win_col,
	output logic [ch_bits-1:0] win_ch
);

	act_word_t bank [4];
	act_t [win_taps-1:0] win_next;
	logic [1:0] ty; // pixel row inside the 4x4 tile
	logic [1:0] tx;
	logic [1:0] bsel;
	logic [1:0] lane;

	assign bank[0] = act_rdata0;
	assign bank[1] = act_rdata1;
	assign bank[2] = act_rdata2;
	assign bank[3] = act_rdata3;

	// tile block (i,j) lives in bank {row[1]^i, col[1]^j}
	always_comb begin
		for (int ch = 0; ch < ch_num; ch++) begin
			for (int ky = 0; ky < kernel_dim; ky++) begin
				for (int kx = 0; kx < kernel_dim; kx++) begin
					ty = 2'(ky) + 2'(issue_row[0]);
					tx = 2'(kx) + 2'(issue_col[0]);
					bsel = {issue_row[1] ^ ty[1], issue_col[1] ^ tx[1]};
					lane = {ty[0], tx[0]};
					win_next[ch*taps + ky*kernel_dim + kx] =
						bank[bsel][slot_lsb(ch*lanes_per_word + int'(lane)) +: act_bits];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			win_valid <= 1'b0;
		else
			win_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		win_act <= win_next;
		win_row <= issue_row;
		win_col <= issue_col;
		win_ch <= issue_ch;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
source/conv_pkg.sv
source/conv_sequencer.sv
source/window_select.sv
source/conv_mac.sv
source/result_writer.sv
source/conv_layer_top.sv
testbench/conv_mem_model.sv
testbench/conv_layer_tb.sv

// ==== testbench/conv_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb import conv_pkg::*; ();

	localparam int timeout_cycles = 2000; // two runs of about 175 cycles, reset, margin
	localparam int seed = 4301;
	localparam int pixels = oc_num * out_dim * out_dim;

	logic clk = 1'b0;
	logic rst_n;
	logic start_req;
	logic start_ack;
	logic [bank_addr_bits-1:0] act_raddr0, act_raddr1, act_raddr2, act_raddr3;
	act_word_t act_rdata0, act_rdata1, act_rdata2, act_rdata3;
	logic [weight_addr_bits-1:0] weight_raddr;
	weight_word_t weight_rdata;
	logic [bias_addr_bits-1:0] bias_raddr;
	bias_t bias_rdata;
	logic out_wen0, out_wen1, out_wen2, out_wen3;
	logic [bank_addr_bits-1:0] out_waddr;
	logic [mask_bits-1:0] out_wordmask;
	act_word_t out_wdata;

	int act_px [ch_num][in_dim][in_dim];
	int wgt [oc_num][ch_num][taps];
	int bias_v [oc_num];
	act_word_t out_bank [4][bank_depth]; // group B model
	int wr_count [oc_num][out_dim][out_dim];
	int writes = 0;
	int errors = 0;
	int cycles = 0;
	logic [31:0] rng = 32'(seed);
	logic prev_ack = 1'b0;
	logic prev_req = 1'b0;

	conv_layer_top i_conv_layer_top (.*);
	conv_mem_model i_conv_mem_model (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// signed value from the low bits of the next number
	function automatic int draw(input int bits);
		rng = xorshift32(rng);
		return int'($signed(rng << (32 - bits))) >>> (32 - bits);
	endfunction

	function automatic int lane_lsb(input int slot);
		return word_bits - (slot + 1) * act_bits; // slot 0 in the top bits
	endfunction

	function automatic int expected_pixel(input int oc, input int r, input int c);
		int acc;
		acc = bias_v[oc];
		for (int ic = 0; ic < ch_num; ic++)
			for (int ky = 0; ky < kernel_dim; ky++)
				for (int kx = 0; kx < kernel_dim; kx++)
					acc += act_px[ic][r+ky][c+kx] * wgt[oc][ic][ky*kernel_dim + kx];
		acc = acc >>> frac_shift;
		if (acc < 0)
			acc = 0;
		else if (acc > act_max)
			acc = act_max;
		return acc;
	endfunction

	task automatic note_error(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic fill_stimulus(input bit directed);
		for (int ch = 0; ch < ch_num; ch++)
			for (int y = 0; y < in_dim; y++)
				for (int x = 0; x < in_dim; x++)
					act_px[ch][y][x] = directed ? 1024 + (draw(11) & 1023) : draw(act_bits);
		for (int oc = 0; oc < oc_num; oc++) begin
			for (int ic = 0; ic < ch_num; ic++)
				for (int k = 0; k < taps; k++)
					if (directed && oc == 0)
						wgt[oc][ic][k] = 100 + (draw(4) & 15);
					else if (directed && oc == 1)
						wgt[oc][ic][k] = -100 - (draw(4) & 15);
					else
						wgt[oc][ic][k] = draw(5); // small, -16..15
			bias_v[oc] = draw(param_bits);
		end
	endtask

	task automatic load_memories();
		act_word_t words [4][bank_depth];
		weight_word_t w;
		int br;
		int bc;
		int s;
		for (int b = 0; b < 4; b++)
			for (int a = 0; a < bank_depth; a++)
				words[b][a] = '0;
		for (int ch = 0; ch < ch_num; ch++)
			for (int y = 0; y < in_dim; y++)
				for (int x = 0; x < in_dim; x++) begin
					br = y / 2;
					bc = x / 2;
					s = ch * lanes_per_word + (y % 2) * 2 + x % 2;
					words[(br % 2) * 2 + bc % 2][(br / 2) * block_pitch + bc / 2]
						[lane_lsb(s) +: act_bits] = act_bits'(act_px[ch][y][x]);
				end
		for (int b = 0; b < 4; b++)
			for (int a = 0; a < bank_depth; a++)
				i_conv_mem_model.act_mem[b][a] = words[b][a];
		for (int oc = 0; oc < oc_num; oc++) begin
			for (int ic = 0; ic < ch_num; ic++) begin
				w = '0;
				for (int k = 0; k < taps; k++)
					w[(taps - 1 - k) * param_bits +: param_bits] = param_bits'(wgt[oc][ic][k]);
				i_conv_mem_model.weight_mem[oc * ch_num + ic] = w;
			end
			i_conv_mem_model.bias_mem[oc] = param_bits'(bias_v[oc]);
		end
	endtask

	task automatic clear_results();
		for (int b = 0; b < 4; b++)
			for (int a = 0; a < bank_depth; a++)
				out_bank[b][a] = '0;
		for (int oc = 0; oc < oc_num; oc++)
			for (int r = 0; r < out_dim; r++)
				for (int c = 0; c < out_dim; c++)
					wr_count[oc][r][c] = 0;
		writes = 0;
	endtask

	task automatic run_layer();
		@(posedge clk);
		#1 start_req = 1'b1;
		do @(negedge clk); while (!start_ack);
		@(posedge clk);
		#1 start_req = 1'b0;
		do @(negedge clk); while (start_ack);
	endtask

	task automatic check_outputs(input bit directed);
		int got;
		int exp;
		int br;
		int bc;
		int s;
		assert (writes == pixels) else
			note_error($sformatf("%0d writes in the run, expected %0d", writes, pixels));
		for (int oc = 0; oc < oc_num; oc++)
			for (int r = 0; r < out_dim; r++)
				for (int c = 0; c < out_dim; c++) begin
					br = r / 2;
					bc = c / 2;
					s = oc * lanes_per_word + (r % 2) * 2 + c % 2;
					got = int'(out_bank[(br % 2) * 2 + bc % 2][(br / 2) * block_pitch + bc / 2]
						[lane_lsb(s) +: act_bits]);
					exp = expected_pixel(oc, r, c);
					assert (wr_count[oc][r][c] == 1) else
						note_error($sformatf("ch %0d (%0d,%0d) written %0d times",
							oc, r, c, wr_count[oc][r][c]));
					assert (got == exp) else
						note_error($sformatf("ch %0d (%0d,%0d) got %0d expected %0d",
							oc, r, c, got, exp));
					if (directed && oc < 2) begin
						assert (got == (oc == 0 ? act_max : 0)) else
							note_error($sformatf("ch %0d (%0d,%0d) not at its limit, got %0d",
								oc, r, c, got));
					end
				end
	endtask

	// write port watch, group B model and handshake rules
	always @(negedge clk) begin
		int low;
		int b;
		int s;
		int r;
		int c;
		act_word_t keep;
		low = $countones(~{out_wen3, out_wen2, out_wen1, out_wen0});
		if (!rst_n) begin
			assert (low == 0 && !start_ack) else
				note_error("write enable or start_ack active during reset");
		end else begin
			if (start_ack && !prev_ack) begin
				assert (start_req) else note_error("start_ack rose without start_req");
			end
			if (prev_ack && prev_req) begin
				assert (start_ack) else note_error("start_ack fell while start_req was high");
			end
			assert (low <= 1) else note_error($sformatf("%0d bank enables low at once", low));
			if (low == 0) begin
				assert (&out_wordmask) else note_error("word mask not all ones without a write");
			end
			if (low == 1) begin
				b = !out_wen0 ? 0 : (!out_wen1 ? 1 : (!out_wen2 ? 2 : 3));
				s = 0;
				for (int i = 0; i < mask_bits; i++)
					if (!out_wordmask[mask_bits - 1 - i])
						s = i;
				keep = '0;
				keep[lane_lsb(s) +: act_bits] = '1;
				r = ((int'(out_waddr) / block_pitch) * 2 + b / 2) * 2 + (s % lanes_per_word) / 2;
				c = ((int'(out_waddr) % block_pitch) * 2 + b % 2) * 2 + s % 2;
				assert (!start_ack) else note_error("write while start_ack high");
				assert ($countones(~out_wordmask) == 1) else
					note_error($sformatf("word mask %h clears more than one slot", out_wordmask));
				assert ((out_wdata & ~keep) == '0) else
					note_error($sformatf("write data nonzero outside slot %0d", s));
				assert (r < out_dim && c < out_dim) else
					note_error($sformatf("bank %0d addr %0d is no output block", b, out_waddr));
				for (int i = 0; i < mask_bits; i++)
					if (!out_wordmask[mask_bits - 1 - i])
						out_bank[b][out_waddr][lane_lsb(i) +: act_bits] =
							out_wdata[lane_lsb(i) +: act_bits];
				if (r < out_dim && c < out_dim)
					wr_count[s / lanes_per_word][r][c]++;
				writes++;
			end
		end
		prev_ack = start_ack;
		prev_req = start_req;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout: layer runs still busy after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		start_req = 1'b0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;

		fill_stimulus(1'b0); // random maps and small weights
		load_memories();
		clear_results();
		run_layer();
		check_outputs(1'b0);

		fill_stimulus(1'b1); // saturation on ch 0, relu on ch 1
		load_memories();
		clear_results();
		run_layer();
		check_outputs(1'b1);

		$display("done: %0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/conv_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mem_model import conv_pkg::*; (
	input  logic clk,
	input  logic [bank_addr_bits-1:0] act_raddr0,
	input  logic [bank_addr_bits-1:0] act_raddr1,
	input  logic [bank_addr_bits-1:0] act_raddr2,
	input  logic [bank_addr_bits-1:0] act_raddr3,
	output act_word_t act_rdata0,
	output act_word_t act_rdata1,
	output act_word_t act_rdata2,
	output act_word_t act_rdata3,
	input  logic [weight_addr_bits-1:0] weight_raddr,
	output weight_word_t weight_rdata,
	input  logic [bias_addr_bits-1:0] bias_raddr,
	output bias_t bias_rdata
);

	act_word_t act_mem [4][bank_depth]; // group A, bank then word
	weight_word_t weight_mem [oc_num*ch_num];
	bias_t bias_mem [oc_num];

	initial begin
		for (int b = 0; b < 4; b++)
			for (int a = 0; a < bank_depth; a++)
				act_mem[b][a] = '0;
		for (int i = 0; i < oc_num*ch_num; i++)
			weight_mem[i] = '0;
		for (int i = 0; i < oc_num; i++)
			bias_mem[i] = '0;
		act_rdata0 = '0;
		act_rdata1 = '0;
		act_rdata2 = '0;
		act_rdata3 = '0;
		weight_rdata = '0;
		bias_rdata = '0;
	end

	// one cycle read latency on every port
	always @(posedge clk) begin
		act_rdata0 <= act_mem[0][act_raddr0];
		act_rdata1 <= act_mem[1][act_raddr1];
		act_rdata2 <= act_mem[2][act_raddr2];
		act_rdata3 <= act_mem[3][act_raddr3];
		weight_rdata <= weight_mem[weight_raddr];
		bias_rdata <= bias_mem[bias_raddr];
	end

endmodule

`default_nettype wire
